/* hw/mlp_pkg.sv */
// Shared constants for the AXI4-Lite MLP classifier
// Register index comes from address bits 3:2 and higher bits are ignored
// Weights and biases are signed Q8.8 and all sums wrap at 16 bits
// Network is 16 binary inputs, 4 ReLU hidden neurons, 4 output classes

package mlp_pkg;

    // ==================================================
    // Bus and register map
    // ==================================================
    localparam int ADDR_WIDTH    = 32;
    localparam int DATA_WIDTH    = 32;
    localparam int REG_NUM       = 4;
    localparam int REG_IDX_WIDTH = 2;

    localparam logic [REG_IDX_WIDTH-1:0] REG_FEATURES = 2'd0; // Low 16 bits kept
    localparam logic [REG_IDX_WIDTH-1:0] REG_RESULT   = 2'd1; // Read starts inference
    localparam logic [REG_IDX_WIDTH-1:0] REG_SCRATCH0 = 2'd2;
    localparam logic [REG_IDX_WIDTH-1:0] REG_SCRATCH1 = 2'd3;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ==================================================
    // Network shape and number format
    // ==================================================
    localparam int INPUT_SIZE  = 16;
    localparam int HIDDEN_SIZE = 4;
    localparam int OUTPUT_SIZE = 4;
    localparam int CLASS_WIDTH = 2;

    localparam int FX_WIDTH = 16; // Q8.8
    localparam int FX_SHIFT = 8;

    // Words 0-15 layer 1 per feature, 16-19 layer 2 per hidden neuron
    localparam int ROM_DEPTH = 20;
    localparam int ROM_WIDTH = 64; // Lane k serves neuron or class k

    localparam logic signed [FX_WIDTH-1:0] BIAS1 [HIDDEN_SIZE] =
        '{16'sh0040, 16'shffe0, 16'sh0010, 16'sh0000};
    localparam logic signed [FX_WIDTH-1:0] BIAS2 [OUTPUT_SIZE] =
        '{16'sh0020, 16'shfff0, 16'sh0008, 16'sh0000};

    // Core latency from first sampled req to ack
    localparam int INFER_CYCLES = 22;

    typedef enum logic [2:0] {
        IDLE, WRITE, WRESP, RADDR, INFER, RDATA
    } axi_state_t;

endpackage

/* hw/infer_if.sv */
// Four-phase request/acknowledge link between bus slave and inference core
// Features must stay stable while req is high

`timescale 1ns/10ps

interface infer_if;
    import mlp_pkg::*;

    logic                   req;
    logic                   ack;
    logic [INPUT_SIZE-1:0]  features;
    logic [CLASS_WIDTH-1:0] prediction; // Valid while ack is high

    modport slave (
        output req, features,
        input  ack, prediction
    );

    modport core (
        input  req, features,
        output ack, prediction
    );

endinterface

/* hw/axi_lite_slave.sv */
// AXI4-Lite slave with one transaction in flight at a time
// Writes are full word (no strobes) and every response is OKAY
// A write wins over a read when both arrive in IDLE
// Reading REG_RESULT holds RVALID off until the core returns a class

`timescale 1ns/10ps

module axi_lite_slave (
    input  logic                          ACLK,
    input  logic                          rst,
    input  logic [mlp_pkg::ADDR_WIDTH-1:0] i_s_awaddr,
    input  logic                          i_s_awvalid,
    output logic                          o_s_awready,
    input  logic [mlp_pkg::DATA_WIDTH-1:0] i_s_wdata,
    input  logic                          i_s_wvalid,
    output logic                          o_s_wready,
    output logic [1:0]                    o_s_bresp,
    output logic                          o_s_bvalid,
    input  logic                          i_s_bready,
    input  logic [mlp_pkg::ADDR_WIDTH-1:0] i_s_araddr,
    input  logic                          i_s_arvalid,
    output logic                          o_s_arready,
    output logic [mlp_pkg::DATA_WIDTH-1:0] o_s_rdata,
    output logic [1:0]                    o_s_rresp,
    output logic                          o_s_rvalid,
    input  logic                          i_s_rready,
    infer_if.slave                        infer
);
    import mlp_pkg::*;

    axi_state_t state;

    logic [DATA_WIDTH-1:0]    regs [REG_NUM];
    logic [REG_IDX_WIDTH-1:0] wr_idx;
    logic [REG_IDX_WIDTH-1:0] ar_idx;
    logic [REG_IDX_WIDTH-1:0] rd_idx;   // Captured at AR handshake
    logic [CLASS_WIDTH-1:0]   result_q; // Last class from the core

    assign wr_idx = i_s_awaddr[REG_IDX_WIDTH+1:2];
    assign ar_idx = i_s_araddr[REG_IDX_WIDTH+1:2];

    // Channel handshakes decoded from state
    assign o_s_awready = (state == WRITE);
    assign o_s_wready  = (state == WRITE);
    assign o_s_bvalid  = (state == WRESP);
    assign o_s_arready = (state == RADDR);
    assign o_s_rvalid  = (state == RDATA);
    assign o_s_bresp   = RESP_OKAY;
    assign o_s_rresp   = RESP_OKAY;

    // Registers cannot change in RDATA, so the read data holds
    assign o_s_rdata = (rd_idx == REG_RESULT) ? DATA_WIDTH'(result_q) : regs[rd_idx];

    assign infer.features = regs[REG_FEATURES][INPUT_SIZE-1:0];

    // ==================================================
    // Channel FSM, register writes, inference exchange
    // ==================================================
    always_ff @(posedge ACLK or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            rd_idx   <= '0;
            result_q <= '0;
            infer.req <= 1'b0;
            for (int r = 0; r < REG_NUM; r++) begin
                regs[r] <= '0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (i_s_awvalid) begin
                        state <= WRITE;
                    end else if (i_s_arvalid) begin
                        state <= RADDR;
                    end
                end
                WRITE: begin
                    if (i_s_awvalid && i_s_wvalid) begin
                        state <= WRESP;
                        if (wr_idx == REG_FEATURES) begin
                            regs[wr_idx] <= DATA_WIDTH'(i_s_wdata[INPUT_SIZE-1:0]);
                        end else if (wr_idx != REG_RESULT) begin
                            regs[wr_idx] <= i_s_wdata;
                        end
                    end
                end
                WRESP: begin
                    if (i_s_bready) state <= IDLE;
                end
                RADDR: begin
                    if (i_s_arvalid) begin
                        rd_idx <= ar_idx;
                        if (ar_idx == REG_RESULT) begin
                            state     <= INFER;
                            infer.req <= ~infer.ack; // Never raise req over a high ack
                        end else begin
                            state <= RDATA;
                        end
                    end
                end
                INFER: begin
                    if (infer.req && infer.ack) begin
                        result_q  <= infer.prediction;
                        infer.req <= 1'b0;
                        state     <= RDATA;
                    end else if (!infer.req && !infer.ack) begin
                        infer.req <= 1'b1;
                    end
                end
                RDATA: begin
                    if (i_s_rready) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* hw/mlp_output_layer.sv */
// Output layer, product of hidden value and lane weight shifted by FX_SHIFT
// o_class is registered one cycle after i_hid_valid falls
// Ties in arg-max go to the lowest class index

`timescale 1ns/10ps

module mlp_output_layer (
    input  logic                                ACLK,
    input  logic                                rst,
    input  logic                                i_hid_valid,
    input  logic signed [mlp_pkg::FX_WIDTH-1:0] i_hid_value,
    input  logic                                i_hid_first,
    input  logic [mlp_pkg::ROM_WIDTH-1:0]       i_weights,
    output logic [mlp_pkg::CLASS_WIDTH-1:0]     o_class
);
    import mlp_pkg::*;

    logic signed [2*FX_WIDTH-1:0] prod  [OUTPUT_SIZE];
    logic signed [FX_WIDTH-1:0]   acc   [OUTPUT_SIZE];
    logic signed [FX_WIDTH-1:0]   score [OUTPUT_SIZE];
    logic [CLASS_WIDTH-1:0]       best;
    logic signed [FX_WIDTH-1:0]   best_score;
    logic                         valid_q;

    always_comb begin
        for (int k = 0; k < OUTPUT_SIZE; k++) begin
            prod[k]  = i_hid_value * signed'(i_weights[k*FX_WIDTH +: FX_WIDTH]);
            score[k] = acc[k] + BIAS2[k];
        end
    end

    always_ff @(posedge ACLK) begin
        if (i_hid_valid) begin
            for (int k = 0; k < OUTPUT_SIZE; k++) begin
                acc[k] <= (i_hid_first ? '0 : acc[k]) + FX_WIDTH'(prod[k] >>> FX_SHIFT);
            end
        end
    end

    // Arg-max, strict compare keeps the lower index
    always_comb begin
        best       = '0;
        best_score = score[0];
        for (int k = 1; k < OUTPUT_SIZE; k++) begin
            if (score[k] > best_score) begin
                best_score = score[k];
                best       = CLASS_WIDTH'(k);
            end
        end
    end

    always_ff @(posedge ACLK or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            o_class <= '0;
        end else begin
            valid_q <= i_hid_valid;
            if (valid_q && !i_hid_valid) o_class <= best; // Last value just added
        end
    end

endmodule

/* hw/mlp_core.sv */
// Inference core, fixed latency of INFER_CYCLES from the first sampled req
// Layer 1 takes one feature bit per cycle for all four neurons at once
// Layer 2 gets one hidden value per cycle in neuron order
// Weight ROM is loaded from hw/mlp_weights.hex, path relative to the run dir

`timescale 1ns/10ps

module mlp_core (
    input  logic   ACLK,
    input  logic   rst,
    infer_if.core  infer
);
    import mlp_pkg::*;

    logic [ROM_WIDTH-1:0] rom [ROM_DEPTH];

    logic                           busy;
    logic                           start;
    logic [$clog2(INFER_CYCLES)-1:0] step;
    logic [$clog2(ROM_DEPTH)-1:0]   rom_addr;
    logic [ROM_WIDTH-1:0]           rom_word;

    logic signed [FX_WIDTH-1:0] acc    [HIDDEN_SIZE];
    logic signed [FX_WIDTH-1:0] hidden [HIDDEN_SIZE];

    logic                              hid_valid;
    logic                              hid_first;
    logic signed [FX_WIDTH-1:0]        hid_value;
    logic [$clog2(HIDDEN_SIZE)-1:0]    hid_sel;
    logic [CLASS_WIDTH-1:0]            layer_class;

    initial begin
        $readmemh("hw/mlp_weights.hex", rom);
    end

    assign start    = infer.req && !infer.ack && !busy;
    assign rom_addr = (step < ROM_DEPTH) ? step : '0;
    assign rom_word = rom[rom_addr];

    // ==================================================
    // Layer 1, masked accumulation of lane weights
    // ==================================================
    always_ff @(posedge ACLK) begin
        if (start) begin
            for (int k = 0; k < HIDDEN_SIZE; k++) acc[k] <= '0;
        end else if (busy && step < INPUT_SIZE
                     && infer.features[step[$clog2(INPUT_SIZE)-1:0]]) begin
            for (int k = 0; k < HIDDEN_SIZE; k++) begin
                acc[k] <= acc[k] + signed'(rom_word[k*FX_WIDTH +: FX_WIDTH]);
            end
        end
    end

    // Bias then ReLU
    always_comb begin
        for (int k = 0; k < HIDDEN_SIZE; k++) begin
            hidden[k] = acc[k] + BIAS1[k];
            if (hidden[k] < 0) hidden[k] = '0;
        end
    end

    // Steps 16..19 stream the hidden values, INPUT_SIZE is a multiple of 4
    assign hid_valid = busy && step >= INPUT_SIZE && step < INPUT_SIZE + HIDDEN_SIZE;
    assign hid_first = busy && step == INPUT_SIZE;
    assign hid_sel   = step[$clog2(HIDDEN_SIZE)-1:0];
    assign hid_value = hidden[hid_sel];

    mlp_output_layer u_output_layer (
        .ACLK        (ACLK),
        .rst         (rst),
        .i_hid_valid (hid_valid),
        .i_hid_value (hid_value),
        .i_hid_first (hid_first),
        .i_weights   (rom_word),
        .o_class     (layer_class)
    );

    // ==================================================
    // Sequencer and handshake
    // ==================================================
    always_ff @(posedge ACLK or posedge rst) begin
        if (rst) begin
            busy             <= 1'b0;
            step             <= '0;
            infer.ack        <= 1'b0;
            infer.prediction <= '0;
        end else begin
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                if (step == INFER_CYCLES - 1) begin // Layer class settled a cycle ago
                    busy             <= 1'b0;
                    infer.ack        <= 1'b1;
                    infer.prediction <= layer_class;
                end else begin
                    step <= step + 1'b1;
                end
            end
            if (infer.ack && !infer.req) infer.ack <= 1'b0;
        end
    end

endmodule

/* hw/mlp_top.sv */
// Top level of the MLP classifier, plain AXI4-Lite slave ports
// i_s_wstrb is accepted but ignored, all writes are full word

`timescale 1ns/10ps

module mlp_top (
    input  logic                          ACLK,
    input  logic                          rst,
    input  logic [mlp_pkg::ADDR_WIDTH-1:0] i_s_awaddr,
    input  logic                          i_s_awvalid,
    output logic                          o_s_awready,
    input  logic [mlp_pkg::DATA_WIDTH-1:0] i_s_wdata,
    input  logic [3:0]                    i_s_wstrb,   // Not used
    input  logic                          i_s_wvalid,
    output logic                          o_s_wready,
    output logic [1:0]                    o_s_bresp,
    output logic                          o_s_bvalid,
    input  logic                          i_s_bready,
    input  logic [mlp_pkg::ADDR_WIDTH-1:0] i_s_araddr,
    input  logic                          i_s_arvalid,
    output logic                          o_s_arready,
    output logic [mlp_pkg::DATA_WIDTH-1:0] o_s_rdata,
    output logic [1:0]                    o_s_rresp,
    output logic                          o_s_rvalid,
    input  logic                          i_s_rready
);

    infer_if u_infer_if ();

    axi_lite_slave u_slave (
        .ACLK        (ACLK),
        .rst         (rst),
        .i_s_awaddr  (i_s_awaddr),
        .i_s_awvalid (i_s_awvalid),
        .o_s_awready (o_s_awready),
        .i_s_wdata   (i_s_wdata),
        .i_s_wvalid  (i_s_wvalid),
        .o_s_wready  (o_s_wready),
        .o_s_bresp   (o_s_bresp),
        .o_s_bvalid  (o_s_bvalid),
        .i_s_bready  (i_s_bready),
        .i_s_araddr  (i_s_araddr),
        .i_s_arvalid (i_s_arvalid),
        .o_s_arready (o_s_arready),
        .o_s_rdata   (o_s_rdata),
        .o_s_rresp   (o_s_rresp),
        .o_s_rvalid  (o_s_rvalid),
        .i_s_rready  (i_s_rready),
        .infer       (u_infer_if.slave)
    );

    mlp_core u_core (
        .ACLK  (ACLK),
        .rst   (rst),
        .infer (u_infer_if.core)
    );

endmodule

/* sim/mlp_top_sva.sv */
// Protocol checks bound into every axi_lite_slave instance
// Covers response hold under back-pressure and the four-phase req/ack link

`timescale 1ns/10ps

module mlp_top_sva (
    input logic                           ACLK,
    input logic                           rst,
    input logic                           i_bvalid,
    input logic                           i_bready,
    input logic                           i_rvalid,
    input logic                           i_rready,
    input logic [mlp_pkg::DATA_WIDTH-1:0] i_rdata,
    input logic                           i_req,
    input logic                           i_ack
);

    // ==================================================
    // AXI response channels
    // ==================================================
    a_bvalid_hold: assert property (@(posedge ACLK) disable iff (rst)
        i_bvalid && !i_bready |=> i_bvalid)
        else $error("BVALID dropped before BREADY");

    a_rvalid_hold: assert property (@(posedge ACLK) disable iff (rst)
        i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
        else $error("RVALID or RDATA changed before RREADY");

    // ==================================================
    // Inference request and acknowledge
    // ==================================================
    a_req_after_ack: assert property (@(posedge ACLK) disable iff (rst)
        !i_req && i_ack |=> !i_req)
        else $error("req raised while ack was still high");

    a_ack_needs_req: assert property (@(posedge ACLK) disable iff (rst)
        $rose(i_ack) |-> $past(i_req))
        else $error("ack rose with no request pending");

endmodule

bind axi_lite_slave mlp_top_sva u_sva (
    .ACLK     (ACLK),
    .rst      (rst),
    .i_bvalid (o_s_bvalid),
    .i_bready (i_s_bready),
    .i_rvalid (o_s_rvalid),
    .i_rready (i_s_rready),
    .i_rdata  (o_s_rdata),
    .i_req    (infer.req),
    .i_ack    (infer.ack)
);

/* sim/tb_mlp_top.sv */
// Testbench for the MLP classifier through its AXI4-Lite slave port
// Must run from the project root, stimulus comes from sim/mlp_golden.txt
// Inputs change 1 ns after the rising edge and outputs are read there too
// B and R ready delays of 0-7 cycles come from an LCG with a fixed seed

`timescale 1ns/10ps

module tb_mlp_top;
    import mlp_pkg::*;

    localparam int CLK_HALF     = 4;  // 8 ns period
    localparam int RST_CYCLES   = 16;
    localparam int DRIVE_DELAY  = 1;
    localparam int ACCEPT_LIMIT = 4;  // Cycles to wait for AWREADY or ARREADY
    localparam int RESULT_LIMIT = INFER_CYCLES + 4;

    logic                  ACLK;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] s_awaddr;
    logic                  s_awvalid;
    logic                  s_awready;
    logic [DATA_WIDTH-1:0] s_wdata;
    logic [3:0]            s_wstrb;
    logic                  s_wvalid;
    logic                  s_wready;
    logic [1:0]            s_bresp;
    logic                  s_bvalid;
    logic                  s_bready;
    logic [ADDR_WIDTH-1:0] s_araddr;
    logic                  s_arvalid;
    logic                  s_arready;
    logic [DATA_WIDTH-1:0] s_rdata;
    logic [1:0]            s_rresp;
    logic                  s_rvalid;
    logic                  s_rready;

    // Golden entries, one per F or S line
    logic [7:0]             kinds   [$];
    logic [DATA_WIDTH-1:0]  words   [$];
    logic [CLASS_WIDTH-1:0] classes [$];
    int                     file_lines    = 0;
    logic                   golden_loaded = 1'b0;

    int          mismatches   = 0;
    int          other_errors = 0;
    logic [31:0] lcg_state    = 32'hd9ee_de07;

    mlp_top i_mlp_top (
        .ACLK        (ACLK),
        .rst         (rst),
        .i_s_awaddr  (s_awaddr),
        .i_s_awvalid (s_awvalid),
        .o_s_awready (s_awready),
        .i_s_wdata   (s_wdata),
        .i_s_wstrb   (s_wstrb),
        .i_s_wvalid  (s_wvalid),
        .o_s_wready  (s_wready),
        .o_s_bresp   (s_bresp),
        .o_s_bvalid  (s_bvalid),
        .i_s_bready  (s_bready),
        .i_s_araddr  (s_araddr),
        .i_s_arvalid (s_arvalid),
        .o_s_arready (s_arready),
        .o_s_rdata   (s_rdata),
        .o_s_rresp   (s_rresp),
        .o_s_rvalid  (s_rvalid),
        .i_s_rready  (s_rready)
    );

    always #CLK_HALF ACLK = ~ACLK;

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [ADDR_WIDTH-1:0] reg_addr(input logic [REG_IDX_WIDTH-1:0] idx);
        return ADDR_WIDTH'({idx, 2'b00});
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_delay(output int delay);
        lcg_state = lcg_next(lcg_state);
        delay     = int'(lcg_state[31:29]); // Top bits are the most random
    endtask

    task automatic draw_word(output logic [31:0] word);
        lcg_state = lcg_next(lcg_state);
        word      = lcg_state;
    endtask

    task automatic next_cycle();
        @(posedge ACLK);
        #DRIVE_DELAY;
    endtask

    task automatic report_mismatch(input string signal, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("MISMATCH %s (%s) expected 0x%h got 0x%h at %0t",
                 signal, what, expected, actual, $time);
        mismatches++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR %s at %0t", what, $time);
        other_errors++;
    endtask

    task automatic print_summary();
        $display("Run finished with %0d mismatches and %0d other errors",
                 mismatches, other_errors);
    endtask

    // Comment lines start with #, F and S lines are stored in file order
    task automatic load_golden();
        int                    fd;
        int                    ch;
        logic [7:0]            tag;
        logic [DATA_WIDTH-1:0] word;
        logic [DATA_WIDTH-1:0] cls;
        fd = $fopen("sim/mlp_golden.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open sim/mlp_golden.txt");
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            file_lines++;
            if (tag == "#") begin
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (tag == "F" && $fscanf(fd, "%h %h", word, cls) == 2) begin
                kinds.push_back(tag);
                words.push_back(word);
                classes.push_back(cls[CLASS_WIDTH-1:0]);
            end else if (tag == "S" && $fscanf(fd, "%h", word) == 1) begin
                kinds.push_back(tag);
                words.push_back(word);
                classes.push_back('0);
            end else begin
                report_failure($sformatf("unreadable golden line %0d", file_lines));
            end
        end
        $fclose(fd);
    endtask

    // ==================================================
    // Bus transactions
    // ==================================================
    task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data);
        int waited;
        int delay;
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        waited    = 0;
        while (!(s_awready && s_wready) && waited < ACCEPT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!(s_awready && s_wready)) begin
            report_failure($sformatf("write to 0x%h was never accepted", addr));
            s_awvalid = 1'b0;
            s_wvalid  = 1'b0;
            return;
        end
        next_cycle();                         // AW and W taken on this edge
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        if (!s_bvalid) begin
            report_failure($sformatf("no write response one cycle after writing 0x%h", addr));
            return;
        end
        assert (s_bresp == RESP_OKAY)
            else report_mismatch("o_s_bresp", "write", RESP_OKAY, s_bresp);
        draw_delay(delay);
        repeat (delay) begin
            next_cycle();
            assert (s_bvalid) else report_mismatch("o_s_bvalid", "held", 1, s_bvalid);
        end
        s_bready = 1'b1;
        next_cycle();
        s_bready = 1'b0;
    endtask

    task automatic read_check(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] expected,
                              input int wait_limit, input string what);
        int                    waited;
        int                    delay;
        logic [DATA_WIDTH-1:0] held;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        waited    = 0;
        while (!s_arready && waited < ACCEPT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!s_arready) begin
            report_failure($sformatf("read of 0x%h was never accepted", addr));
            s_arvalid = 1'b0;
            return;
        end
        next_cycle();                         // AR taken on this edge
        s_arvalid = 1'b0;
        waited    = 0;
        while (!s_rvalid && waited < wait_limit) begin
            next_cycle();
            waited++;
        end
        if (!s_rvalid) begin
            report_failure($sformatf("no read data within %0d cycles for 0x%h",
                                     wait_limit, addr));
            return;
        end
        held = s_rdata;
        assert (s_rresp == RESP_OKAY) else report_mismatch("o_s_rresp", what, RESP_OKAY, s_rresp);
        assert (held == expected) else report_mismatch("o_s_rdata", what, expected, held);
        draw_delay(delay);
        repeat (delay) begin
            next_cycle();
            assert (s_rvalid) else report_mismatch("o_s_rvalid", "held", 1, s_rvalid);
            assert (s_rdata == held) else report_mismatch("o_s_rdata", "held", held, s_rdata);
        end
        s_rready = 1'b1;
        next_cycle();
        s_rready = 1'b0;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin : main_seq
        logic [DATA_WIDTH-1:0] junk;
        ACLK      = 1'b0;
        rst       = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = 4'hf;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        load_golden();
        golden_loaded = 1'b1;

        repeat (RST_CYCLES) @(posedge ACLK);
        #DRIVE_DELAY;
        rst = 1'b0;
        next_cycle();

        // Idle bus right after reset
        assert (!s_awready) else report_mismatch("o_s_awready", "after reset", 0, s_awready);
        assert (!s_wready) else report_mismatch("o_s_wready", "after reset", 0, s_wready);
        assert (!s_bvalid) else report_mismatch("o_s_bvalid", "after reset", 0, s_bvalid);
        assert (!s_arready) else report_mismatch("o_s_arready", "after reset", 0, s_arready);
        assert (!s_rvalid) else report_mismatch("o_s_rvalid", "after reset", 0, s_rvalid);

        foreach (kinds[i]) begin
            if (kinds[i] == "S") begin
                write_reg(reg_addr(REG_SCRATCH0), words[i]);
                write_reg(reg_addr(REG_SCRATCH1), words[i]);
                read_check(reg_addr(REG_SCRATCH0), words[i], 0, "scratch0");
                read_check(reg_addr(REG_SCRATCH1), words[i], 0, "scratch1");
            end else begin
                write_reg(reg_addr(REG_FEATURES), words[i]);
                read_check(reg_addr(REG_FEATURES), {16'h0000, words[i][INPUT_SIZE-1:0]},
                           0, "features");
                draw_word(junk);
                write_reg(reg_addr(REG_RESULT), junk); // Result register ignores writes
                read_check(reg_addr(REG_RESULT), DATA_WIDTH'(classes[i]), RESULT_LIMIT,
                           $sformatf("class for 0x%h", words[i]));
            end
        end

        print_summary();
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Budget of INFER_CYCLES + 20 cycles per golden line
    initial begin : watchdog
        wait (golden_loaded);
        repeat (file_lines * (INFER_CYCLES + 20) + 100) @(posedge ACLK);
        report_failure("watchdog expired before the test sequence finished");
        print_summary();
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* hw/mlp_weights.hex */
// Each word packs four Q8.8 weights, lane 3 on the left and lane 0 on the right
// Words 0-15 are layer 1 per feature bit, words 16-19 are layer 2 per hidden neuron
0000000000000100
0000000000000100
0000000000000100
0000000000000100
0000000001000000
0000000001000000
0000000001000000
0000000001000000
0000010000000000
0000010000000000
0000010000000000
0000010000000000
0100000000000000
0100000000000000
0100000000000000
0100000000000000
ff80000000000200
000000000200ff80
00000200ff800000
0200ff8000000000

/* sim/mlp_golden.txt */
# F lines hold a feature word and the expected class, both in hex
# S lines hold a scratch register value in hex
F 00000000 0
S 12345678
F 000000f0 1
F abcd0f00 2
F 0000f000 3
S deadbeef
F ffff000f 0
F 00000111 0
S 00000000
F 00003311 3
F 00001300 2
S ffffffff
F 0000ffff 0
F 5a5aff0f 0
F 0000fff0 3
F 00000ff0 2
F 000000f1 1

/* list.f */
hw/mlp_pkg.sv
hw/infer_if.sv
hw/axi_lite_slave.sv
hw/mlp_output_layer.sv
hw/mlp_core.sv
hw/mlp_top.sv
sim/mlp_top_sva.sv
sim/tb_mlp_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the MLP classifier testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mlp_top -f list.f -o sim_mlp
./obj_dir/sim_mlp | tee sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"
